/* all.f */
design/preif_pkg.sv
design/pc_sel_ctrl.sv
design/pc_gen.sv
design/itlb_buffer.sv
design/fetch_req.sv
design/preif_top.sv
dv/preif_tb.sv

/* design/fetch_req.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_req import preif_pkg::*; (
    input  wire addr_t                 pc,
    input  wire addr_t                 phys_addr,
    input  wire                        cached,
    input  wire                        buf_valid,
    input  wire                        ireq_valid,
    input  wire [1:0]                  tlb_exc,
    output logic                       req_valid,
    output logic                       req_cached,
    output logic [ICACHE_TAG_W-1:0]    req_tag,
    output logic [ICACHE_INDEX_W-1:0]  req_index,
    output logic [ICACHE_OFFSET_W-1:0] req_offset,
    output except_t                    except_type
);

    logic aligned;

    assign aligned = (pc[1:0] == 2'b00);

    assign req_tag                 = phys_addr[31:12];
    assign {req_index, req_offset} = pc[11:0];    // untranslated page offset
    assign req_cached              = cached;

    assign req_valid = ireq_valid && buf_valid && (tlb_exc == TLB_EXC_NONE) && aligned;

    always_comb begin
        except_type = '0;
        case (tlb_exc)
            TLB_EXC_REFILL:  except_type[EXC_TLB_REFILL_BIT]  = 1'b1;
            TLB_EXC_INVALID: except_type[EXC_TLB_INVALID_BIT] = 1'b1;
            default:         except_type = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/itlb_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module itlb_buffer import preif_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         tlb_flush,
    input  wire addr_t  pc,
    input  wire         tlb_found,
    input  wire vpn2_t  tlb_vpn2,
    input  wire pfn_t   tlb_pfn0,
    input  wire pfn_t   tlb_pfn1,
    input  wire cattr_t tlb_c0,
    input  wire cattr_t tlb_c1,
    input  wire         tlb_v0,
    input  wire         tlb_v1,
    output vpn2_t       vpn2_req,
    output addr_t       phys_addr,
    output logic        cached,
    output logic        buf_valid,
    output logic        tlb_stall,
    output logic [1:0]  tlb_exc
);

    // stored entry
    logic   ent_valid;
    logic   ent_found;
    vpn2_t  ent_vpn2;
    pfn_t   ent_pfn0;
    pfn_t   ent_pfn1;
    cattr_t ent_c0;
    cattr_t ent_c1;
    logic   ent_v0;
    logic   ent_v1;

    logic   kseg0;
    logic   kseg1;
    logic   mapped;
    logic   hit;
    logic   odd_page;
    pfn_t   sel_pfn;
    cattr_t sel_c;
    logic   sel_v;

    assign vpn2_req = pc[31:13];

    assign kseg0  = (pc[31:29] == 3'b100);    // 8xxx_xxxx, 9xxx_xxxx
    assign kseg1  = (pc[31:29] == 3'b101);    // axxx_xxxx, bxxx_xxxx
    assign mapped = !(kseg0 || kseg1);

    assign hit      = ent_valid && (ent_vpn2 == pc[31:13]);
    assign odd_page = pc[12];

    assign sel_pfn = odd_page ? ent_pfn1 : ent_pfn0;
    assign sel_c   = odd_page ? ent_c1   : ent_c0;
    assign sel_v   = odd_page ? ent_v1   : ent_v0;

    assign tlb_stall = mapped && !hit;
    assign buf_valid = !mapped || hit;

    always_comb begin
        if (mapped) begin
            phys_addr = {sel_pfn, pc[11:0]};
            cached    = (sel_c == CATTR_CACHED);
        end else begin
            phys_addr = {3'b000, pc[28:0]};
            cached    = kseg0;
        end
    end

    always_comb begin
        tlb_exc = TLB_EXC_NONE;
        if (mapped && hit) begin
            if (!ent_found) begin
                tlb_exc = TLB_EXC_REFILL;
            end else if (!sel_v) begin
                tlb_exc = TLB_EXC_INVALID;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || tlb_flush) begin
            ent_valid <= 1'b0;
        end else if (tlb_stall) begin
            ent_valid <= 1'b1;
        end
    end

    // one refill cycle per miss
    always_ff @(posedge clk) begin
        if (tlb_stall) begin
            ent_found <= tlb_found;
            // a missing page is kept under the requested vpn2 so the refill is reported
            ent_vpn2  <= tlb_found ? tlb_vpn2 : pc[31:13];
            ent_pfn0  <= tlb_pfn0;
            ent_pfn1  <= tlb_pfn1;
            ent_c0    <= tlb_c0;
            ent_c1    <= tlb_c1;
            ent_v0    <= tlb_v0;
            ent_v1    <= tlb_v1;
        end
    end

endmodule

`default_nettype wire

/* design/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_gen import preif_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire pc_sel_e pc_sel,
    input  wire          pc_load,
    input  wire addr_t   epc,
    input  wire addr_t   except_vector,
    input  wire addr_t   refetch_pc,
    input  wire addr_t   correction_pc,
    input  wire addr_t   bpu_target,
    output addr_t        pc
);

    addr_t pc_plus4;
    addr_t next_pc;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (pc_sel)
            SEL_ERET:    next_pc = epc;
            SEL_EXCEPT:  next_pc = except_vector;
            SEL_REFETCH: next_pc = refetch_pc;      // replay from a later stage
            SEL_CORRECT: next_pc = correction_pc;   // branch mispredict
            SEL_BPU:     next_pc = bpu_target;
            SEL_SEQ:     next_pc = pc_plus4;
            default:     next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* design/pc_sel_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_sel_ctrl import preif_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             pc_wr,
    input  wire entry_sel_t entry_sel,
    input  wire             prediction_failed,
    input  wire             bpu_valid,
    input  wire             tlb_stall,
    output pc_sel_e         pc_sel,
    output logic            pc_load
);

    logic first_cycle;    // cycle right after reset
    logic entry_req;
    logic correct_req;
    logic redirect;

    always_ff @(posedge clk) begin
        if (reset) begin
            first_cycle <= 1'b1;
        end else begin
            first_cycle <= 1'b0;
        end
    end

    // the reset vector issues before any pipeline request is honoured
    assign entry_req   = (entry_sel != ENTRY_NONE) && !first_cycle;
    assign correct_req = prediction_failed && !first_cycle;
    assign redirect    = entry_req || correct_req;

    always_comb begin
        pc_sel = SEL_SEQ;
        if (entry_req) begin
            case (entry_sel)
                ENTRY_ERET:    pc_sel = SEL_ERET;
                ENTRY_EXCEPT:  pc_sel = SEL_EXCEPT;
                ENTRY_REFETCH: pc_sel = SEL_REFETCH;
                default:       pc_sel = SEL_SEQ;
            endcase
        end else if (correct_req) begin
            pc_sel = SEL_CORRECT;
        end else if (bpu_valid && !first_cycle) begin
            pc_sel = SEL_BPU;
        end
    end

    // a redirect may leave a stalled fetch behind
    assign pc_load = pc_wr && (!tlb_stall || redirect);

endmodule

`default_nettype wire

/* design/preif_pkg.sv */
`default_nettype none

package preif_pkg;

    typedef logic [31:0] addr_t;    // virtual or physical address
    typedef logic [18:0] vpn2_t;    // address bits 31:13
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [18:0] except_t;
    typedef logic [1:0]  entry_sel_t;

    localparam addr_t  RESET_VECTOR = 32'hbfc0_0000;

    localparam int     EXC_TLB_REFILL_BIT  = 8;
    localparam int     EXC_TLB_INVALID_BIT = 7;

    // icache geometry, 128 sets of 32-byte lines
    localparam int     ICACHE_INDEX_W  = 7;
    localparam int     ICACHE_OFFSET_W = 5;
    localparam int     ICACHE_TAG_W    = 20;

    localparam cattr_t CATTR_CACHED = 3'd3;

    // requests coming back from later stages
    localparam entry_sel_t ENTRY_NONE    = 2'd0;
    localparam entry_sel_t ENTRY_ERET    = 2'd1;
    localparam entry_sel_t ENTRY_EXCEPT  = 2'd2;
    localparam entry_sel_t ENTRY_REFETCH = 2'd3;

    // itlb exception codes
    localparam logic [1:0] TLB_EXC_NONE    = 2'd0;
    localparam logic [1:0] TLB_EXC_REFILL  = 2'd1;
    localparam logic [1:0] TLB_EXC_INVALID = 2'd2;

    typedef enum logic [2:0] {
        SEL_ERET,
        SEL_EXCEPT,
        SEL_REFETCH,
        SEL_CORRECT,
        SEL_BPU,
        SEL_SEQ
    } pc_sel_e;

endpackage

`default_nettype wire

/* design/preif_top.sv */
`timescale 1ns/1ps
`default_nettype none

module preif_top import preif_pkg::*; (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        pc_wr,
    input  wire entry_sel_t            entry_sel,
    input  wire addr_t                 epc,
    input  wire addr_t                 except_vector,
    input  wire addr_t                 refetch_pc,
    input  wire                        prediction_failed,
    input  wire addr_t                 correction_pc,
    input  wire                        bpu_valid,
    input  wire addr_t                 bpu_target,
    input  wire                        tlb_flush,
    input  wire                        tlb_found,
    input  wire vpn2_t                 tlb_vpn2,
    input  wire pfn_t                  tlb_pfn0,
    input  wire cattr_t                tlb_c0,
    input  wire                        tlb_v0,
    input  wire pfn_t                  tlb_pfn1,
    input  wire cattr_t                tlb_c1,
    input  wire                        tlb_v1,
    input  wire                        ireq_valid,
    output addr_t                      pc,
    output vpn2_t                      vpn2_req,
    output logic                       tlb_stall,
    output logic                       req_valid,
    output logic [ICACHE_TAG_W-1:0]    req_tag,
    output logic [ICACHE_INDEX_W-1:0]  req_index,
    output logic [ICACHE_OFFSET_W-1:0] req_offset,
    output logic                       req_cached,
    output except_t                    except_type
);

    pc_sel_e    pc_sel;
    logic       pc_load;
    addr_t      phys_addr;
    logic       cached;
    logic       buf_valid;
    logic [1:0] tlb_exc;

    pc_sel_ctrl u_pc_sel_ctrl (
        .clk               (clk),
        .reset             (reset),
        .pc_wr             (pc_wr),
        .entry_sel         (entry_sel),
        .prediction_failed (prediction_failed),
        .bpu_valid         (bpu_valid),
        .tlb_stall         (tlb_stall),
        .pc_sel            (pc_sel),
        .pc_load           (pc_load)
    );

    pc_gen u_pc_gen (
        .clk           (clk),
        .reset         (reset),
        .pc_sel        (pc_sel),
        .pc_load       (pc_load),
        .epc           (epc),
        .except_vector (except_vector),
        .refetch_pc    (refetch_pc),
        .correction_pc (correction_pc),
        .bpu_target    (bpu_target),
        .pc            (pc)
    );

    itlb_buffer u_itlb_buffer (
        .clk       (clk),
        .reset     (reset),
        .tlb_flush (tlb_flush),
        .pc        (pc),
        .tlb_found (tlb_found),
        .tlb_vpn2  (tlb_vpn2),
        .tlb_pfn0  (tlb_pfn0),
        .tlb_pfn1  (tlb_pfn1),
        .tlb_c0    (tlb_c0),
        .tlb_c1    (tlb_c1),
        .tlb_v0    (tlb_v0),
        .tlb_v1    (tlb_v1),
        .vpn2_req  (vpn2_req),
        .phys_addr (phys_addr),
        .cached    (cached),
        .buf_valid (buf_valid),
        .tlb_stall (tlb_stall),
        .tlb_exc   (tlb_exc)
    );

    fetch_req u_fetch_req (
        .pc          (pc),
        .phys_addr   (phys_addr),
        .cached      (cached),
        .buf_valid   (buf_valid),
        .ireq_valid  (ireq_valid),
        .tlb_exc     (tlb_exc),
        .req_valid   (req_valid),
        .req_cached  (req_cached),
        .req_tag     (req_tag),
        .req_index   (req_index),
        .req_offset  (req_offset),
        .except_type (except_type)
    );

endmodule

`default_nettype wire

/* dv/preif_golden.txt */
# in: pc_wr entry_sel epc except_vector refetch_pc prediction_failed correction_pc bpu_valid
#     bpu_target tlb_flush tlb_found tlb_vpn2 tlb_pfn0 tlb_c0 tlb_v0 tlb_pfn1 tlb_c1 tlb_v1 ireq_valid
# out: pc tlb_stall req_valid req_tag req_index req_offset req_cached except_type (all hex)
# reset vector, sequential fetch, hold on low pc_wr
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  bfc00000 0 1 1fc00 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  bfc00004 0 1 1fc00 0 4 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  bfc00008 0 1 1fc00 0 8 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  bfc00008 0 1 1fc00 0 8 0 0
# redirect priority, kseg0 and kseg1 translation
1 1 80001000 80000180 80002000 1 80003000 1 80004000 0 0 0 0 0 0 0 0 0 1  bfc0000c 0 1 1fc00 0 c 0 0
1 2 80001000 80000180 80002000 1 80003000 1 80004000 0 0 0 0 0 0 0 0 0 1  80001000 0 1 1 0 0 1 0
1 3 80001000 80000180 80002000 1 80003000 1 80004000 0 0 0 0 0 0 0 0 0 1  80000180 0 1 0 c 0 1 0
1 0 80001000 80000180 80002000 1 80003000 1 80004000 0 0 0 0 0 0 0 0 0 1  80002000 0 1 2 0 0 1 0
1 0 0 0 0 0 0 1 80004000 0 0 0 0 0 0 0 0 0 1  80003000 0 1 3 0 0 1 0
1 0 0 0 0 0 0 1 a0005020 0 0 0 0 0 0 0 0 0 1  80004000 0 1 4 0 0 1 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  a0005020 0 1 5 1 0 0 0
# mapped miss and refill, even then odd page
1 0 0 0 0 1 402ff0 0 0 0 0 0 0 0 0 0 0 0 1  a0005024 0 1 5 1 4 0 0
1 0 0 0 0 0 0 0 0 0 1 201 12345 3 1 abcd 2 1 1  402ff0 1 0 0 7f 10 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  402ff0 0 1 12345 7f 10 1 0
1 0 0 0 0 0 0 1 403000 0 0 0 0 0 0 0 0 0 1  402ff4 0 1 12345 7f 14 1 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  403000 0 1 abcd 0 0 0 0
# flush, invalid page, refill exception
1 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 1  403004 0 1 abcd 0 4 0 0
1 0 0 0 0 0 0 0 0 0 1 201 12345 3 1 abcd 3 0 1  403008 1 0 0 0 8 0 0
1 0 0 0 0 1 800000 0 0 0 0 0 0 0 0 0 0 0 1  403008 0 0 abcd 0 8 1 80
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  800000 1 0 0 0 0 0 0
1 0 0 0 0 1 80000102 0 0 0 0 0 0 0 0 0 0 0 1  800000 0 0 0 0 0 0 100
# misaligned target, then ireq_valid low
1 0 0 0 0 0 0 1 80000200 0 0 0 0 0 0 0 0 0 1  80000102 0 0 0 8 2 1 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  80000200 0 0 0 10 0 1 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  80000204 0 1 0 10 4 1 0

/* dv/preif_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module preif_tb import preif_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_COLS   = 27;     // 19 stimulus + 8 expected
    localparam int MAX_LINES  = 200;

    logic       clk;
    logic       reset;
    logic       pc_wr;
    entry_sel_t entry_sel;
    addr_t      epc;
    addr_t      except_vector;
    addr_t      refetch_pc;
    logic       prediction_failed;
    addr_t      correction_pc;
    logic       bpu_valid;
    addr_t      bpu_target;
    logic       tlb_flush;
    logic       tlb_found;
    vpn2_t      tlb_vpn2;
    pfn_t       tlb_pfn0;
    cattr_t     tlb_c0;
    logic       tlb_v0;
    pfn_t       tlb_pfn1;
    cattr_t     tlb_c1;
    logic       tlb_v1;
    logic       ireq_valid;

    addr_t                      pc;
    vpn2_t                      vpn2_req;
    logic                       tlb_stall;
    logic                       req_valid;
    logic [ICACHE_TAG_W-1:0]    req_tag;
    logic [ICACHE_INDEX_W-1:0]  req_index;
    logic [ICACHE_OFFSET_W-1:0] req_offset;
    logic                       req_cached;
    except_t                    except_type;

    logic [31:0] col [0:NUM_COLS-1];    // fields of the current golden line
    int          error_count = 0;

    preif_top dut0 (
        .clk               (clk),
        .reset             (reset),
        .pc_wr             (pc_wr),
        .entry_sel         (entry_sel),
        .epc               (epc),
        .except_vector     (except_vector),
        .refetch_pc        (refetch_pc),
        .prediction_failed (prediction_failed),
        .correction_pc     (correction_pc),
        .bpu_valid         (bpu_valid),
        .bpu_target        (bpu_target),
        .tlb_flush         (tlb_flush),
        .tlb_found         (tlb_found),
        .tlb_vpn2          (tlb_vpn2),
        .tlb_pfn0          (tlb_pfn0),
        .tlb_c0            (tlb_c0),
        .tlb_v0            (tlb_v0),
        .tlb_pfn1          (tlb_pfn1),
        .tlb_c1            (tlb_c1),
        .tlb_v1            (tlb_v1),
        .ireq_valid        (ireq_valid),
        .pc                (pc),
        .vpn2_req          (vpn2_req),
        .tlb_stall         (tlb_stall),
        .req_valid         (req_valid),
        .req_tag           (req_tag),
        .req_index         (req_index),
        .req_offset        (req_offset),
        .req_cached        (req_cached),
        .except_type       (except_type)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic parse_line(input logic [8*256-1:0] text, output int n_fields);
        n_fields = $sscanf(text,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
            col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16],
            col[17], col[18], col[19], col[20], col[21], col[22], col[23], col[24],
            col[25], col[26]);
    endtask

    task automatic drive_inputs();
        pc_wr             <= col[0][0];
        entry_sel         <= col[1][1:0];
        epc               <= col[2];
        except_vector     <= col[3];
        refetch_pc        <= col[4];
        prediction_failed <= col[5][0];
        correction_pc     <= col[6];
        bpu_valid         <= col[7][0];
        bpu_target        <= col[8];
        tlb_flush         <= col[9][0];
        tlb_found         <= col[10][0];
        tlb_vpn2          <= col[11][18:0];
        tlb_pfn0          <= col[12][19:0];
        tlb_c0            <= col[13][2:0];
        tlb_v0            <= col[14][0];
        tlb_pfn1          <= col[15][19:0];
        tlb_c1            <= col[16][2:0];
        tlb_v1            <= col[17][0];
        ireq_valid        <= col[18][0];
    endtask

    task automatic check_outputs();
        check_value("pc", col[19], pc);
        check_value("vpn2_req", 32'(col[19][31:13]), 32'(vpn2_req));    // page pair of the pc
        check_value("tlb_stall", col[20], 32'(tlb_stall));
        check_value("req_valid", col[21], 32'(req_valid));
        check_value("req_index", col[23], 32'(req_index));
        check_value("req_offset", col[24], 32'(req_offset));
        check_value("except_type", col[26], 32'(except_type));
        if (col[20][0] == 1'b0) begin    // translation is undefined during a refill
            check_value("req_tag", col[22], 32'(req_tag));
            check_value("req_cached", col[25], 32'(req_cached));
        end
    endtask

    initial begin
        int               fd;
        int               n_fields;
        int               line_count;
        int               vec_count;
        logic             done;
        logic [8*256-1:0] line_buf;

        line_count        = 0;
        vec_count         = 0;
        done              = 1'b0;
        reset             = 1'b1;
        pc_wr             = 1'b0;
        entry_sel         = ENTRY_NONE;
        epc               = '0;
        except_vector     = '0;
        refetch_pc        = '0;
        prediction_failed = 1'b0;
        correction_pc     = '0;
        bpu_valid         = 1'b0;
        bpu_target        = '0;
        tlb_flush         = 1'b0;
        tlb_found         = 1'b0;
        tlb_vpn2          = '0;
        tlb_pfn0          = '0;
        tlb_c0            = '0;
        tlb_v0            = 1'b0;
        tlb_pfn1          = '0;
        tlb_c1            = '0;
        tlb_v1            = 1'b0;
        ireq_valid        = 1'b0;

        fd = $fopen("dv/preif_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/preif_golden.txt");
            error_count++;
        end else begin
            repeat (2) @(posedge clk);
            reset <= 1'b0;
            while (!done) begin
                line_buf = '0;
                if (line_count >= MAX_LINES) begin
                    $display("golden file runs past %0d lines, stopping the run", MAX_LINES);
                    error_count++;
                    done = 1'b1;
                end else if ($fgets(line_buf, fd) == 0) begin
                    done = 1'b1;
                end else begin
                    line_count++;
                    parse_line(line_buf, n_fields);
                    if (n_fields == NUM_COLS) begin
                        drive_inputs();
                        #(CLK_PERIOD - 10);    // just before the next rising edge
                        check_outputs();
                        vec_count++;
                        @(posedge clk);
                    end else if (n_fields > 0) begin
                        $display("golden line %0d holds %0d fields, not %0d",
                                 line_count, n_fields, NUM_COLS);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            if (vec_count == 0) begin
                $display("no test vectors were found in the golden file");
                error_count++;
            end
        end

        $display("checked %0d cycles, %0d errors", vec_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the pre-fetch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f all.f --top-module preif_tb -o preif_sim

sim_out=$(./obj_dir/preif_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
else
    exit 1
fi
